// File: logic/memsys_pkg.sv
// Memory subsystem package with widths, address map, response codes and shared types
package memsys_pkg;

  // Bus and scratchpad geometry
  localparam int AXI_ADDR_W = 12;
  localparam int DATA_W     = 32;
  localparam int MEM_DEPTH  = 128;
  localparam int IDX_W      = $clog2(MEM_DEPTH);

  typedef logic [AXI_ADDR_W-1:0] axil_addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [IDX_W-1:0]      word_idx_t;
  typedef logic [1:0]            reg_sel_t;

  // Scratchpad window, one 32-bit word per 4 bytes
  localparam axil_addr_t MEM_BASE = 12'h000;
  localparam int         MEM_SPAN = MEM_DEPTH * (DATA_W / 8);
  localparam axil_addr_t MEM_MASK = axil_addr_t'(MEM_SPAN - 1);

  // Control and status registers
  localparam axil_addr_t REG_CTRL    = 12'h800;
  localparam axil_addr_t REG_PATTERN = 12'h804;
  localparam axil_addr_t REG_STATUS  = 12'h808;

  // Register select codes passed from the front end to the register block
  localparam reg_sel_t SEL_CTRL    = 2'd0;
  localparam reg_sel_t SEL_PATTERN = 2'd1;
  localparam reg_sel_t SEL_STATUS  = 2'd2;

  // Bit positions inside CTRL and STATUS
  localparam int CTRL_START_BIT = 0;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_DONE_BIT  = 1;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Front end transaction states
  typedef enum logic [2:0] {IDLE, MEM_WAIT, MEM_READ, WRITE_RESP, READ_RESP} axil_state_t;

endpackage

// File: logic/spsram.sv
// Single-port SRAM with synchronous write and registered read data
module spsram #(
  parameter int W = 32,
  parameter int N = 128
) (
  input  logic                 clk,
  input  logic                 en,
  input  logic                 wen,
  input  logic [$clog2(N)-1:0] addr,
  input  logic [W-1:0]         din,
  output logic [W-1:0]         dout
);

  // Storage array
  logic [W-1:0] mem [N];

  logic do_write;
  logic do_read;

  // A write needs both enables, a read is an enable without write
  assign do_write = en & wen;
  assign do_read  = en & ~wen;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[addr] <= din;
    end
  end

  // Read data appears on the cycle after the enable and holds until the next read
  always_ff @(posedge clk) begin
    if (do_read) begin
      dout <= mem[addr];
    end
  end

  // An access outside the array would alias when N is not a power of two
  addr_in_range_a: assert property (@(posedge clk) en |-> (int'(addr) < N))
    else $error("spsram address %0d out of range", addr);

endmodule

// File: logic/axil_front.sv
// AXI4-Lite slave front end that routes single accesses to the scratchpad or registers
module axil_front (
  input  logic                   clk,
  input  logic                   arst_n,
  // Write address and data channels
  input  logic                   awvalid,
  output logic                   awready,
  input  memsys_pkg::axil_addr_t awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  memsys_pkg::data_t      wdata,
  input  logic [3:0]             wstrb,
  // Write response channel
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  // Read address and data channels
  input  logic                   arvalid,
  output logic                   arready,
  input  memsys_pkg::axil_addr_t araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output memsys_pkg::data_t      rdata,
  output logic [1:0]             rresp,
  // Scratchpad port towards the fill engine
  output logic                   mem_req,
  output logic                   mem_we,
  output memsys_pkg::word_idx_t  mem_idx,
  output memsys_pkg::data_t      mem_wdata,
  input  logic                   mem_gnt,
  input  memsys_pkg::data_t      mem_rdata,
  // Register block strobes
  output logic                   reg_we,
  output memsys_pkg::reg_sel_t   reg_sel,
  output memsys_pkg::data_t      reg_wdata,
  input  memsys_pkg::data_t      reg_rdata
);

  import memsys_pkg::*;

  axil_state_t state;

  logic       aw_fire;
  logic       ar_fire;
  axil_addr_t cur_addr;
  logic       hit_mem;
  logic       hit_reg;
  logic       strb_ok;
  reg_sel_t   sel;

  // Address and data are taken together, and only from IDLE
  assign aw_fire = (state == IDLE) && awvalid && wvalid;

  // A read goes ahead only when no complete write is waiting
  assign ar_fire = (state == IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = aw_fire;
  assign wready  = aw_fire;
  assign arready = ar_fire;

  // The write address wins when both channels present
  assign cur_addr = aw_fire ? awaddr : araddr;

  // Only full-word writes are supported
  assign strb_ok = (wstrb == 4'hf);

  // Address decode into the scratchpad window or one of the registers
  always_comb begin
    hit_mem = ((cur_addr & ~MEM_MASK) == MEM_BASE);
    hit_reg = 1'b1;
    case (cur_addr)
      REG_CTRL:    sel = SEL_CTRL;
      REG_PATTERN: sel = SEL_PATTERN;
      REG_STATUS:  sel = SEL_STATUS;
      default: begin
        sel     = SEL_CTRL;
        hit_reg = 1'b0;
      end
    endcase
  end

  // Register strobes fire on the transfer edge so reads can be answered next cycle
  assign reg_we    = aw_fire && hit_reg && strb_ok;
  assign reg_sel   = sel;
  assign reg_wdata = wdata;

  // The memory request is held for as long as the FSM waits for the grant
  assign mem_req = (state == MEM_WAIT);

  assign bvalid = (state == WRITE_RESP);
  assign rvalid = (state == READ_RESP);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (aw_fire) begin
            state <= (hit_mem && strb_ok) ? MEM_WAIT : WRITE_RESP;
          end else if (ar_fire) begin
            state <= hit_mem ? MEM_WAIT : READ_RESP;
          end
        end
        MEM_WAIT: begin
          // A granted write is done at the grant edge, a read needs one more cycle
          if (mem_gnt) begin
            state <= mem_we ? WRITE_RESP : MEM_READ;
          end
        end
        MEM_READ:   state <= READ_RESP;
        WRITE_RESP: if (bready) state <= IDLE;
        READ_RESP:  if (rready) state <= IDLE;
        default:    state <= IDLE;
      endcase
    end
  end

  // Transaction payload is captured at the transfer and then held
  always_ff @(posedge clk) begin
    if (aw_fire || ar_fire) begin
      mem_we    <= aw_fire;
      mem_idx   <= cur_addr[IDX_W+1:2];
      mem_wdata <= wdata;
      bresp     <= ((hit_mem || hit_reg) && strb_ok) ? RESP_OKAY : RESP_SLVERR;
      rresp     <= (hit_mem || hit_reg) ? RESP_OKAY : RESP_SLVERR;
      // Register reads answer at once, unmapped reads return zero
      rdata     <= hit_reg ? reg_rdata : '0;
    end else if (state == MEM_READ) begin
      rdata <= mem_rdata;
    end
  end

  // Only one transaction is ever in its response phase
  one_resp_a: assert property (@(posedge clk) disable iff (!arst_n)
    !(bvalid && rvalid));

  // A stalled write response keeps its code
  b_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  // A stalled read response keeps its code and data
  r_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
    rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata));

  // The request is withdrawn only after the fill engine has granted it
  req_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
    mem_req && !mem_gnt |=> mem_req);

endmodule

// File: logic/fill_regs.sv
// Control and status registers that start the fill engine and report its progress
module fill_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 reg_we,
  input  memsys_pkg::reg_sel_t reg_sel,
  input  memsys_pkg::data_t    reg_wdata,
  output memsys_pkg::data_t    reg_rdata,
  input  logic                 fill_busy,
  input  logic                 fill_done_pulse,
  output logic                 fill_start,
  output memsys_pkg::data_t    fill_pattern
);

  import memsys_pkg::*;

  logic done_q;
  logic start_req;

  // A start bit written to CTRL counts only while no fill is running
  assign start_req = reg_we && (reg_sel == SEL_CTRL) && reg_wdata[CTRL_START_BIT] && !fill_busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_start   <= 1'b0;
      fill_pattern <= '0;
      done_q       <= 1'b0;
    end else begin
      // One-cycle pulse in the cycle after the CTRL write
      fill_start <= start_req;
      if (reg_we && (reg_sel == SEL_PATTERN)) begin
        fill_pattern <= reg_wdata;
      end
      // Done is sticky until the next start
      if (fill_start) begin
        done_q <= 1'b0;
      end else if (fill_done_pulse) begin
        done_q <= 1'b1;
      end
    end
  end

  // Read mux, CTRL reads back as zero since start is self-clearing
  always_comb begin
    reg_rdata = '0;
    case (reg_sel)
      SEL_PATTERN: reg_rdata = fill_pattern;
      SEL_STATUS: begin
        reg_rdata[STAT_BUSY_BIT] = fill_busy;
        reg_rdata[STAT_DONE_BIT] = done_q;
      end
      default: reg_rdata = '0;
    endcase
  end

  // The engine must have gone idle before another start is issued
  start_idle_a: assert property (@(posedge clk) disable iff (!arst_n)
    fill_start |-> !fill_busy);

endmodule

// File: logic/fill_engine.sv
// Fill engine that writes a pattern over the whole scratchpad and arbitrates the SRAM port
module fill_engine (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  fill_start,
  input  memsys_pkg::data_t     fill_pattern,
  output logic                  fill_busy,
  output logic                  fill_done_pulse,
  // Host side of the memory port
  input  logic                  mem_req,
  input  logic                  mem_we,
  input  memsys_pkg::word_idx_t mem_idx,
  input  memsys_pkg::data_t     mem_wdata,
  output logic                  mem_gnt,
  output memsys_pkg::data_t     mem_rdata,
  // SRAM side
  output logic                  sram_en,
  output logic                  sram_wen,
  output memsys_pkg::word_idx_t sram_addr,
  output memsys_pkg::data_t     sram_din,
  input  memsys_pkg::data_t     sram_dout
);

  import memsys_pkg::*;

  word_idx_t fill_idx;
  data_t     pattern_q;

  // Last word of the sweep ends the fill
  assign fill_done_pulse = fill_busy && (fill_idx == word_idx_t'(MEM_DEPTH - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fill_busy <= 1'b0;
      fill_idx  <= '0;
    end else if (fill_busy) begin
      fill_idx <= fill_idx + 1'b1;
      if (fill_done_pulse) begin
        fill_busy <= 1'b0;
      end
    end else if (fill_start) begin
      fill_busy <= 1'b1;
      fill_idx  <= '0;
    end
  end

  // The pattern is frozen for the whole sweep
  always_ff @(posedge clk) begin
    if (fill_start && !fill_busy) begin
      pattern_q <= fill_pattern;
    end
  end

  // Host requests are granted whenever the sweep is not running
  assign mem_gnt = !fill_busy;

  // Port mux, the sweep owns the SRAM while busy
  assign sram_en   = fill_busy || mem_req;
  assign sram_wen  = fill_busy || mem_we;
  assign sram_addr = fill_busy ? fill_idx : mem_idx;
  assign sram_din  = fill_busy ? pattern_q : mem_wdata;

  // Registered SRAM output already lines up with the granted read
  assign mem_rdata = sram_dout;

  // The sweep steps one word per cycle and only wraps on the done pulse
  idx_step_a: assert property (@(posedge clk) disable iff (!arst_n)
    fill_busy && !fill_done_pulse |=>
      fill_busy && (fill_idx == word_idx_t'($past(fill_idx) + 1'b1)) && (fill_idx != '0));

endmodule

// File: logic/memsys_top.sv
// Memory subsystem top joining the AXI4-Lite front end, registers, fill engine and SRAM
module memsys_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   awvalid,
  output logic                   awready,
  input  memsys_pkg::axil_addr_t awaddr,
  input  logic                   wvalid,
  output logic                   wready,
  input  memsys_pkg::data_t      wdata,
  input  logic [3:0]             wstrb,
  output logic                   bvalid,
  input  logic                   bready,
  output logic [1:0]             bresp,
  input  logic                   arvalid,
  output logic                   arready,
  input  memsys_pkg::axil_addr_t araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output memsys_pkg::data_t      rdata,
  output logic [1:0]             rresp
);

  import memsys_pkg::*;

  // Front end to fill engine
  logic      mem_req;
  logic      mem_we;
  word_idx_t mem_idx;
  data_t     mem_wdata;
  logic      mem_gnt;
  data_t     mem_rdata;

  // Front end to register block
  logic      reg_we;
  reg_sel_t  reg_sel;
  data_t     reg_wdata;
  data_t     reg_rdata;

  // Register block to fill engine
  logic      fill_start;
  data_t     fill_pattern;
  logic      fill_busy;
  logic      fill_done_pulse;

  // Fill engine to SRAM
  logic      sram_en;
  logic      sram_wen;
  word_idx_t sram_addr;
  data_t     sram_din;
  data_t     sram_dout;

  axil_front front0 (
    .clk(clk), .arst_n(arst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .mem_req(mem_req), .mem_we(mem_we), .mem_idx(mem_idx), .mem_wdata(mem_wdata),
    .mem_gnt(mem_gnt), .mem_rdata(mem_rdata),
    .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
  );

  fill_regs regs0 (
    .clk(clk), .arst_n(arst_n),
    .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .fill_busy(fill_busy), .fill_done_pulse(fill_done_pulse),
    .fill_start(fill_start), .fill_pattern(fill_pattern)
  );

  fill_engine fill0 (
    .clk(clk), .arst_n(arst_n),
    .fill_start(fill_start), .fill_pattern(fill_pattern),
    .fill_busy(fill_busy), .fill_done_pulse(fill_done_pulse),
    .mem_req(mem_req), .mem_we(mem_we), .mem_idx(mem_idx), .mem_wdata(mem_wdata),
    .mem_gnt(mem_gnt), .mem_rdata(mem_rdata),
    .sram_en(sram_en), .sram_wen(sram_wen), .sram_addr(sram_addr),
    .sram_din(sram_din), .sram_dout(sram_dout)
  );

  // Scratchpad storage sized from the package
  spsram #(
    .W(DATA_W),
    .N(MEM_DEPTH)
  ) mem0 (
    .clk(clk), .en(sram_en), .wen(sram_wen), .addr(sram_addr),
    .din(sram_din), .dout(sram_dout)
  );

endmodule

// File: tests/memsys_tb.sv
// Testbench for the memory subsystem that applies a table of AXI4-Lite accesses and checks them
module memsys_tb;

  import memsys_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int SETTLE      = 10;
  localparam int MAX_TESTS   = 64;
  localparam int POLL_TRIES  = MEM_DEPTH;

  // Table operations
  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_POLL  = 2'd2;

  logic       clk;
  logic       arst_n;
  logic       awvalid;
  logic       awready;
  axil_addr_t awaddr;
  logic       wvalid;
  logic       wready;
  data_t      wdata;
  logic [3:0] wstrb;
  logic       bvalid;
  logic       bready;
  logic [1:0] bresp;
  logic       arvalid;
  logic       arready;
  axil_addr_t araddr;
  logic       rvalid;
  logic       rready;
  data_t      rdata;
  logic [1:0] rresp;

  // One stimulus table entry per transaction or status poll
  logic [1:0] t_op       [MAX_TESTS];
  axil_addr_t t_addr     [MAX_TESTS];
  data_t      t_data     [MAX_TESTS];
  logic [3:0] t_strb     [MAX_TESTS];
  int         t_delay    [MAX_TESTS];
  data_t      t_exp_data [MAX_TESTS];
  logic [1:0] t_exp_resp [MAX_TESTS];
  string      t_name     [MAX_TESTS];
  int         num_tests;

  // Scratchpad model and the pattern register contents seen by the next fill
  data_t model [MEM_DEPTH];
  data_t pattern_shadow;

  logic [31:0] lcg_state;
  int          cycle_count = 0;
  int          timeout_limit;

  memsys_top dut0 (
    .clk(clk), .arst_n(arst_n),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      abort_run();
    end
  endtask

  // Every clock counts against a budget sized from the table and two full fills
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles without finishing the test table", cycle_count);
      abort_run();
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Scratchpad window starts at address zero
  function automatic logic in_scratchpad(axil_addr_t addr);
    return addr < axil_addr_t'(MEM_SPAN);
  endfunction

  function automatic logic is_register(axil_addr_t addr);
    return (addr == REG_CTRL) || (addr == REG_PATTERN) || (addr == REG_STATUS);
  endfunction

  function automatic axil_addr_t mem_addr(word_idx_t idx);
    return axil_addr_t'({idx, 2'b00});
  endfunction

  task automatic add_entry(string name, logic [1:0] op, axil_addr_t addr, data_t data,
                           logic [3:0] strb, int delay, data_t exp_data, logic [1:0] exp_resp);
    t_op[num_tests]       = op;
    t_addr[num_tests]     = addr;
    t_data[num_tests]     = data;
    t_strb[num_tests]     = strb;
    t_delay[num_tests]    = delay;
    t_exp_data[num_tests] = exp_data;
    t_exp_resp[num_tests] = exp_resp;
    t_name[num_tests]     = name;
    num_tests++;
  endtask

  // A write entry also updates the model as the address map defines it
  task automatic add_write(string name, axil_addr_t addr, data_t data, logic [3:0] strb,
                           int delay);
    logic ok;
    int   i;
    ok = (in_scratchpad(addr) || is_register(addr)) && (strb == 4'hf);
    if (ok && in_scratchpad(addr)) begin
      model[addr[IDX_W+1:2]] = data;
    end
    if (ok && (addr == REG_PATTERN)) begin
      pattern_shadow = data;
    end
    // Host accesses wait for the whole fill, so a start rewrites the model at once
    if (ok && (addr == REG_CTRL) && data[CTRL_START_BIT]) begin
      for (i = 0; i < MEM_DEPTH; i++) begin
        model[i] = pattern_shadow;
      end
    end
    add_entry(name, OP_WRITE, addr, data, strb, delay, '0, ok ? RESP_OKAY : RESP_SLVERR);
  endtask

  // A read entry takes its expected STATUS value from status_exp
  task automatic add_read(string name, axil_addr_t addr, int delay, data_t status_exp);
    data_t exp;
    logic  mapped;
    mapped = in_scratchpad(addr) || is_register(addr);
    if (in_scratchpad(addr)) begin
      exp = model[addr[IDX_W+1:2]];
    end else if (addr == REG_PATTERN) begin
      exp = pattern_shadow;
    end else if (addr == REG_STATUS) begin
      exp = status_exp;
    end else begin
      exp = '0;
    end
    add_entry(name, OP_READ, addr, '0, 4'hf, delay, exp, mapped ? RESP_OKAY : RESP_SLVERR);
  endtask

  task automatic add_poll(string name, data_t mask);
    add_entry(name, OP_POLL, REG_STATUS, '0, 4'hf, 0, mask, RESP_OKAY);
  endtask

  task automatic build_table();
    int          i;
    logic [31:0] r;
    word_idx_t   idx [8];
    // Random words at random indices are read back in reverse order
    for (i = 0; i < 8; i++) begin
      r = lcg_next();
      idx[i] = word_idx_t'(r[22:16]);
      add_write($sformatf("random write %0d", i), mem_addr(idx[i]), lcg_next(), 4'hf, 0);
    end
    for (i = 7; i >= 0; i--) begin
      add_read($sformatf("random read %0d", i), mem_addr(idx[i]), 0, '0);
    end
    // Pattern register and a full fill watched through STATUS
    add_write("pattern write", REG_PATTERN, lcg_next(), 4'hf, 0);
    add_read("pattern read", REG_PATTERN, 0, '0);
    add_write("fill start", REG_CTRL, 32'd1, 4'hf, 0);
    add_read("status busy", REG_STATUS, 0, 32'd1);
    add_poll("fill done poll", 32'd2);
    add_read("status done", REG_STATUS, 0, 32'd2);
    for (i = 0; i < 6; i++) begin
      add_read($sformatf("filled word %0d", i * 25), mem_addr(word_idx_t'(i * 25)), 0, '0);
    end
    // A second start clears the done flag and host traffic follows right behind it
    add_write("pattern 2 write", REG_PATTERN, lcg_next(), 4'hf, 0);
    add_write("fill 2 start", REG_CTRL, 32'd1, 4'hf, 0);
    add_read("status busy after fill 2 start", REG_STATUS, 0, 32'd1);
    add_write("early index write during fill", mem_addr(7'd3), lcg_next(), 4'hf, 0);
    add_write("late index write during fill", mem_addr(7'd120), lcg_next(), 4'hf, 0);
    add_read("early index read", mem_addr(7'd3), 0, '0);
    add_read("untouched index read", mem_addr(7'd64), 0, '0);
    add_read("late index read", mem_addr(7'd120), 0, '0);
    add_poll("fill 2 done poll", 32'd2);
    // Unmapped addresses and a partial strobe are refused
    add_read("unmapped read 0x200", 12'h200, 0, '0);
    add_read("unmapped read 0x80c", 12'h80c, 0, '0);
    add_read("unmapped read 0xffc", 12'hffc, 0, '0);
    add_write("unmapped write 0x400", 12'h400, lcg_next(), 4'hf, 0);
    add_write("partial strobe write", mem_addr(7'd3), lcg_next(), 4'h3, 0);
    add_read("word after partial strobe", mem_addr(7'd3), 0, '0);
    // Stalled responses followed by a plain access
    add_write("write with bready stall", mem_addr(7'd50), lcg_next(), 4'hf, 4);
    add_read("read with rready stall", mem_addr(7'd50), 5, '0);
    add_read("register read with rready stall", REG_PATTERN, 3, '0);
    add_read("unmapped read with rready stall", 12'h900, 2, '0);
    add_read("read after stalls", mem_addr(idx[1]), 0, '0);
  endtask

  task automatic axil_write(string name, axil_addr_t addr, data_t data, logic [3:0] strb,
                            int delay, output logic [1:0] resp);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // Ready follows the valids combinationally, so it is sampled mid-cycle
    #SETTLE;
    while (!(awready && wready)) begin
      @(negedge clk);
      #SETTLE;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(negedge clk);
    end
    resp = bresp;
    // With bready low the response has to sit still
    repeat (delay) begin
      @(negedge clk);
      check({name, " bvalid held"}, 32'd1, 32'(bvalid));
      check({name, " bresp held"}, 32'(resp), 32'(bresp));
    end
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(string name, axil_addr_t addr, int delay, output data_t data,
                           output logic [1:0] resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    #SETTLE;
    while (!arready) begin
      @(negedge clk);
      #SETTLE;
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) begin
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    repeat (delay) begin
      @(negedge clk);
      check({name, " rvalid held"}, 32'd1, 32'(rvalid));
      check({name, " rresp held"}, 32'(resp), 32'(rresp));
      check({name, " rdata held"}, data, rdata);
    end
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Reads STATUS until every bit of the mask is set
  task automatic poll_status(string name, data_t mask);
    data_t      rd;
    logic [1:0] resp;
    int         tries;
    tries = 0;
    do begin
      axil_read(name, REG_STATUS, 0, rd, resp);
      check({name, " rresp"}, 32'(RESP_OKAY), 32'(resp));
      tries++;
    end while (((rd & mask) != mask) && (tries < POLL_TRIES));
    if ((rd & mask) != mask) begin
      $display("Status poll %s gave up after %0d reads without the expected bits", name, tries);
      abort_run();
    end
  endtask

  initial begin
    int         i;
    data_t      rd;
    logic [1:0] resp;
    arst_n  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = 4'h0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    lcg_state      = 32'd15821;
    num_tests      = 0;
    pattern_shadow = '0;
    build_table();
    timeout_limit = num_tests * 20 + MEM_DEPTH * 4 + 200;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (i = 0; i < num_tests; i++) begin
      case (t_op[i])
        OP_WRITE: begin
          axil_write(t_name[i], t_addr[i], t_data[i], t_strb[i], t_delay[i], resp);
          check({t_name[i], " bresp"}, 32'(t_exp_resp[i]), 32'(resp));
        end
        OP_READ: begin
          axil_read(t_name[i], t_addr[i], t_delay[i], rd, resp);
          check({t_name[i], " rresp"}, 32'(t_exp_resp[i]), 32'(resp));
          check({t_name[i], " rdata"}, t_exp_data[i], rd);
        end
        default: poll_status(t_name[i], t_exp_data[i]);
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: flist.f
logic/memsys_pkg.sv
logic/spsram.sv
logic/axil_front.sv
logic/fill_regs.sv
logic/fill_engine.sv
logic/memsys_top.sv
tests/memsys_tb.sv

// File: run.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module memsys_tb \
  --Mdir obj_dir -o memsys_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/memsys_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
exit 1
